// ==== list.f ====
src/execPkg.sv
src/alu.sv
src/jumpUnit.sv
src/execute.sv
src/instrDecode.sv
src/regFile.sv
src/execCore.sv
bench/execCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f list.f --top-module execCoreTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== bench/execCoreTb.sv ====
// ********************
// testbench for execCore
// clock, reset, DUT instance, shadow register model,
// directed tests, compare tasks and cycle timeout
// ********************
`timescale 1ns/1ps

module execCoreTb import execPkg::*;;
	localparam int resetCycles = 10;
	localparam int testCycles  = 140;   // issue and drain cycles of all tests
	localparam int cycleLimit  = 2 * (resetCycles + testCycles);

	logic                 clk;
	logic                 rstN;
	logic                 instrValid;
	logic [15:0]          instr;
	logic [dataWidth-1:0] pc;
	logic                 resultValid;
	logic [dataWidth-1:0] result;
	logic [2:0]           resultReg;
	logic                 writeEn;
	logic                 jumpTaken;
	logic [dataWidth-1:0] jumpTarget;
	logic                 err;

	logic [15:0] shadow [8];   // reference registers
	logic [15:0] expResult;
	logic [15:0] expTarget;
	logic [2:0]  expReg;
	logic        expWe;
	logic        expJump;
	logic        expErr;
	logic        pending;
	logic [15:0] curPc;
	int          cycles;
	int          errCount;
	int          checkCount;
	int          testCount;
	int          testErrStart;
	opcodeT      arith [8] = '{opAdd, opSub, opXor, opAndn, opAddi, opSubi, opXori, opAndni};

	execCore #(.width(dataWidth)) execCore_inst (
		.clk         (clk),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.instr       (instr),
		.pc          (pc),
		.resultValid (resultValid),
		.result      (result),
		.resultReg   (resultReg),
		.writeEn     (writeEn),
		.jumpTaken   (jumpTaken),
		.jumpTarget  (jumpTarget),
		.err         (err)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: run went past %0d clock cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [15:0] rForm(opcodeT op, logic [2:0] rs, logic [2:0] rt,
			logic [2:0] rd);
		return {op, rs, rt, rd, 2'b00};
	endfunction

	function automatic logic [15:0] iForm(opcodeT op, logic [2:0] rs, logic [2:0] rd,
			logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] byteForm(opcodeT op, logic [2:0] r, logic [7:0] imm);
		return {op, r, imm};
	endfunction

	task automatic checkData(input string name, input logic [dataWidth-1:0] exp,
			input logic [dataWidth-1:0] act);
		checkCount++;
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected 0x%h got 0x%h", $time, name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkIdx(input string name, input logic [2:0] exp, input logic [2:0] act);
		checkCount++;
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			errCount++;
		end
	endtask

	// expected outcome of one instruction, shadow registers updated
	task automatic predict(input logic [15:0] ins, input logic [15:0] pcVal);
		opcodeT      op;
		logic [15:0] rs;
		logic [15:0] rt;
		logic [15:0] imm5s;
		logic [15:0] imm8s;
		logic [16:0] wide;
		int          sh;
		op        = opcodeT'(ins[15:11]);
		rs        = shadow[ins[10:8]];
		rt        = shadow[ins[7:5]];
		imm5s     = {{11{ins[4]}}, ins[4:0]};
		imm8s     = {{8{ins[7]}}, ins[7:0]};
		sh        = int'(rt[3:0]);
		wide      = {1'b0, rs} + {1'b0, rt};
		expReg    = ins[4:2];
		expResult = '0;
		expTarget = '0;
		expWe     = 1'b1;
		expJump   = 1'b0;
		expErr    = 1'b0;
		case (op)
			opAdd:   expResult = rs + rt;
			opSub:   expResult = rs - rt;
			opXor:   expResult = rs ^ rt;
			opAndn:  expResult = rs & ~rt;
			opAddi:  expResult = rs + imm5s;
			opSubi:  expResult = rs - imm5s;
			opXori:  expResult = rs ^ {11'b0, ins[4:0]};
			opAndni: expResult = rs & ~{11'b0, ins[4:0]};
			opSll:   expResult = rs << sh;
			opSrl:   expResult = rs >> sh;
			opRol:   expResult = (rs << sh) | (rs >> (16 - sh));
			opRor:   expResult = (rs >> sh) | (rs << (16 - sh));
			opSeq:   expResult = {15'b0, rs == rt};
			opSlt:   expResult = {15'b0, $signed(rs) < $signed(rt)};
			opSle:   expResult = {15'b0, $signed(rs) <= $signed(rt)};
			opSco:   expResult = {15'b0, wide[16]};
			opBtr: begin
				for (int i = 0; i < 16; i++) begin
					expResult[i] = rs[15-i];
				end
			end
			opLbi:   expResult = imm8s;
			opSlbi:  expResult = {rs[7:0], ins[7:0]};
			opJ:     expTarget = pcVal + 16'd2 + {{5{ins[10]}}, ins[10:0]};
			opJr:    expTarget = rs + imm8s;
			default: begin
				expErr = 1'b1;   // unknown opcode
				expWe  = 1'b0;
			end
		endcase
		if (op inside {opAddi, opSubi, opXori, opAndni}) expReg = ins[7:5];
		if (op inside {opLbi, opSlbi}) expReg = ins[10:8];
		if (op inside {opJ, opJr}) begin
			expWe   = 1'b0;
			expJump = 1'b1;
			expErr  = expTarget[0];
		end
		if (expWe) shadow[expReg] = expResult;
	endtask

	task automatic checkPending();
		checkFlag("resultValid", 1'b1, resultValid);
		checkFlag("writeEn", expWe, writeEn);
		checkFlag("jumpTaken", expJump, jumpTaken);
		checkFlag("err", expErr, err);
		if (expWe) begin
			checkData("result", expResult, result);
			checkIdx("resultReg", expReg, resultReg);
		end
		if (expJump) checkData("jumpTarget", expTarget, jumpTarget);
	endtask

	// outputs after a cycle with no valid instruction
	task automatic checkIdle();
		checkFlag("resultValid", 1'b0, resultValid);
		checkFlag("writeEn", 1'b0, writeEn);
		checkFlag("jumpTaken", 1'b0, jumpTaken);
		checkFlag("err", 1'b0, err);
	endtask

	// one instruction per cycle; the previous one is checked a cycle later
	task automatic issue(input logic [15:0] ins);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= ins;
		pc         <= curPc;
		@(negedge clk);
		if (pending) checkPending();
		else checkIdle();
		predict(ins, curPc);
		pending = 1'b1;
		curPc   = curPc + 16'd2;
	endtask

	task automatic drain();
		@(posedge clk);
		instrValid <= 1'b0;
		@(negedge clk);
		if (pending) checkPending();
		pending = 1'b0;
	endtask

	task automatic loadReg(input logic [2:0] r, input logic [15:0] v);
		issue(byteForm(opLbi, r, v[15:8]));
		issue(byteForm(opSlbi, r, v[7:0]));
	endtask

	task automatic readReg(input logic [2:0] r);
		issue(iForm(opAddi, r, r, 5'd0));   // result is the register itself
	endtask

	task automatic startTest();
		testCount++;
		testErrStart = errCount;
	endtask

	task automatic endTest(input string name);
		if (errCount == testErrStart) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errCount - testErrStart);
	endtask

	task automatic testResetState();
		startTest();
		for (int r = 0; r < 8; r++) begin
			readReg(3'(r));
		end
		drain();
		endTest("reset state");
	endtask

	task automatic testArith();
		logic [2:0] src;
		logic [2:0] dst;
		logic [2:0] k;
		startTest();
		for (int r = 0; r < 8; r++) begin
			loadReg(3'(r), 16'($urandom));
		end
		src = 3'($urandom);
		repeat (12) begin
			k   = 3'($urandom);
			dst = 3'($urandom);
			if (k >= 3'd4) issue(iForm(arith[k], src, dst, 5'($urandom)));
			else issue(rForm(arith[k], src, 3'($urandom), dst));
			src = dst;   // chain on the last result
		end
		drain();
		endTest("load and arithmetic");
	endtask

	task automatic testShifts();
		startTest();
		repeat (3) begin
			loadReg(3'd1, 16'($urandom));
			loadReg(3'd2, 16'($urandom));
			issue(rForm(opSll, 3'd1, 3'd2, 3'd3));
			issue(rForm(opSrl, 3'd1, 3'd2, 3'd4));
			issue(rForm(opRol, 3'd1, 3'd2, 3'd5));
			issue(rForm(opRor, 3'd1, 3'd2, 3'd6));
		end
		drain();
		endTest("shifts and rotates");
	endtask

	task automatic comparePair(input logic [15:0] a, input logic [15:0] b);
		loadReg(3'd1, a);
		loadReg(3'd2, b);
		issue(rForm(opSeq, 3'd1, 3'd2, 3'd3));
		issue(rForm(opSlt, 3'd1, 3'd2, 3'd4));
		issue(rForm(opSle, 3'd1, 3'd2, 3'd5));
		issue(rForm(opSco, 3'd1, 3'd2, 3'd6));
	endtask

	task automatic testCompares();
		logic [15:0] a;
		logic [15:0] b;
		startTest();
		a = 16'($urandom);
		comparePair(a, a);
		a = 16'($urandom) & 16'h3fff;
		b = a + 16'h0100;
		comparePair(a, b);
		comparePair(b, a);
		comparePair(16'h8000 | 16'($urandom), 16'h8000 | 16'($urandom));   // carry out
		comparePair(16'h8000 | 16'($urandom), 16'($urandom) & 16'h7fff);
		drain();
		endTest("compare and set");
	endtask

	task automatic testSpecials();
		startTest();
		repeat (4) begin
			loadReg(3'd2, 16'($urandom));
			issue(rForm(opBtr, 3'd2, 3'd0, 3'd3));
			issue(byteForm(opSlbi, 3'd2, 8'($urandom)));
		end
		drain();
		endTest("special results");
	endtask

	task automatic testJumps();
		startTest();
		curPc = 16'($urandom) & 16'hfffe;
		issue({opJ, 11'($urandom) & 11'h3fe});               // forward
		issue({opJ, (11'($urandom) | 11'h400) & 11'h7fe});   // backward
		issue({opJ, 11'($urandom) | 11'h001});               // odd target
		repeat (2) begin
			loadReg(3'd3, 16'($urandom) & 16'hfffe);
			issue(byteForm(opJr, 3'd3, 8'($urandom) & 8'hfe));
		end
		loadReg(3'd4, 16'($urandom) & 16'hfffe);
		issue(byteForm(opJr, 3'd4, 8'($urandom) | 8'h01));
		drain();
		endTest("jumps");
	endtask

	task automatic testIllegal();
		startTest();
		loadReg(3'd5, 16'($urandom));
		issue({5'b00000, 3'd2, 3'd5, 3'd5, 2'b00});
		issue({5'b01111, 3'd1, 3'd5, 3'd5, 2'b01});
		readReg(3'd5);   // old value must survive
		drain();
		endTest("illegal opcode");
	endtask

	initial begin
		clk          = 1'b0;
		rstN         = 1'b0;
		instrValid   = 1'b0;
		instr        = '0;
		pc           = '0;
		curPc        = '0;
		pending      = 1'b0;
		cycles       = 0;
		errCount     = 0;
		checkCount   = 0;
		testCount    = 0;
		testErrStart = 0;
		for (int r = 0; r < 8; r++) begin
			shadow[r] = '0;
		end
		void'($urandom(60));
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		testResetState();
		testArith();
		testShifts();
		testCompares();
		testSpecials();
		testJumps();
		testIllegal();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== src/execCore.sv ====
// ********************
// execCore top level
// decode, register file, execute,
// output registers and write-back
// ********************
`timescale 1ns/1ps

module execCore import execPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             instrValid,
	input  logic [15:0]      instr,
	input  logic [width-1:0] pc,
	output logic             resultValid,
	output logic [width-1:0] result,
	output logic [2:0]       resultReg,
	output logic             writeEn,
	output logic             jumpTaken,
	output logic [width-1:0] jumpTarget,
	output logic             err
);
	logic [2:0]       rsIdx;
	logic [2:0]       rtIdx;
	logic [2:0]       rdIdx;
	logic [width-1:0] immExt;
	logic [10:0]      disp;
	aluOpT            aluOp;
	logic             aluSrc;
	logic             cin;
	logic             invA;
	logic             invB;
	cmpOpT            cmpOp;
	logic             cmpSet;
	specialT          special;
	logic             jumpD;
	logic             jumpI;
	logic             regWrite;
	logic             illegal;
	logic [width-1:0] rsData;
	logic [width-1:0] rtData;
	logic [width-1:0] xOut;
	logic [width-1:0] xTarget;
	logic             xJump;
	logic             jumpErr;
	logic             wrEn;

	instrDecode #(.width(width)) instrDecode_inst (
		.instr    (instr),
		.rsIdx    (rsIdx),
		.rtIdx    (rtIdx),
		.rdIdx    (rdIdx),
		.immExt   (immExt),
		.disp     (disp),
		.aluOp    (aluOp),
		.aluSrc   (aluSrc),
		.cin      (cin),
		.invA     (invA),
		.invB     (invB),
		.cmpOp    (cmpOp),
		.cmpSet   (cmpSet),
		.special  (special),
		.jumpD    (jumpD),
		.jumpI    (jumpI),
		.regWrite (regWrite),
		.illegal  (illegal)
	);

	// write lands at the same edge as the output registers
	assign wrEn = instrValid & regWrite & ~illegal & ~jumpErr;

	regFile #(.width(width)) regFile_inst (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (rsIdx),
		.rdAddrB (rtIdx),
		.wrAddr  (rdIdx),
		.wrEn    (wrEn),
		.wrData  (xOut),
		.rdDataA (rsData),
		.rdDataB (rtData)
	);

	execute #(.width(width)) execute_inst (
		.rsData     (rsData),
		.rtData     (rtData),
		.immExt     (immExt),
		.pc         (pc),
		.disp       (disp),
		.aluOp      (aluOp),
		.aluSrc     (aluSrc),
		.cin        (cin),
		.invA       (invA),
		.invB       (invB),
		.cmpOp      (cmpOp),
		.cmpSet     (cmpSet),
		.special    (special),
		.jumpD      (jumpD),
		.jumpI      (jumpI),
		.xOut       (xOut),
		.jumpTarget (xTarget),
		.jumpTaken  (xJump),
		.jumpErr    (jumpErr)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			writeEn     <= 1'b0;
			jumpTaken   <= 1'b0;
			err         <= 1'b0;
		end else begin
			resultValid <= instrValid;
			writeEn     <= wrEn;
			jumpTaken   <= instrValid & xJump;
			err         <= instrValid & (illegal | jumpErr);   // bad opcode or odd target
		end
	end

	// payload only follows valid instructions
	always_ff @(posedge clk) begin
		if (instrValid) begin
			result     <= xOut;
			resultReg  <= rdIdx;
			jumpTarget <= xTarget;
		end
	end

endmodule

// ==== src/regFile.sv ====
// ********************
// register file, eight entries
// two combinational reads, one clocked write
// ********************
`timescale 1ns/1ps

module regFile import execPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic [2:0]       rdAddrA,
	input  logic [2:0]       rdAddrB,
	input  logic [2:0]       wrAddr,
	input  logic             wrEn,
	input  logic [width-1:0] wrData,
	output logic [width-1:0] rdDataA,
	output logic [width-1:0] rdDataB
);
	logic [width-1:0] regs [8];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// new value seen by the following instruction
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

// ==== src/instrDecode.sv ====
// ********************
// instruction decoder
// register indices, extended immediate,
// execute controls and illegal opcode flag
// ********************
`timescale 1ns/1ps

module instrDecode import execPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic [15:0]      instr,
	output logic [2:0]       rsIdx,
	output logic [2:0]       rtIdx,
	output logic [2:0]       rdIdx,
	output logic [width-1:0] immExt,
	output logic [10:0]      disp,
	output aluOpT            aluOp,
	output logic             aluSrc,
	output logic             cin,
	output logic             invA,
	output logic             invB,
	output cmpOpT            cmpOp,
	output logic             cmpSet,
	output specialT          special,
	output logic             jumpD,
	output logic             jumpI,
	output logic             regWrite,
	output logic             illegal
);
	opcodeT           opcode;
	logic [width-1:0] imm5S;
	logic [width-1:0] imm5Z;
	logic [width-1:0] imm8S;
	logic [width-1:0] imm8Z;

	assign opcode = opcodeT'(instr[15:11]);
	assign rsIdx  = instr[10:8];
	assign rtIdx  = instr[7:5];
	assign disp   = instr[10:0];

	assign imm5S = {{(width-5){instr[4]}}, instr[4:0]};
	assign imm5Z = {{(width-5){1'b0}}, instr[4:0]};
	assign imm8S = {{(width-8){instr[7]}}, instr[7:0]};
	assign imm8Z = {{(width-8){1'b0}}, instr[7:0]};

	always_comb begin
		rdIdx    = instr[4:2];   // R-format unless changed below
		immExt   = imm5S;
		aluOp    = aluAdd;
		aluSrc   = 1'b0;
		cin      = 1'b0;
		invA     = 1'b0;
		invB     = 1'b0;
		cmpOp    = cmpEq;
		cmpSet   = 1'b0;
		special  = spNone;
		jumpD    = 1'b0;
		jumpI    = 1'b0;
		regWrite = 1'b1;
		illegal  = 1'b0;
		case (opcode)
			opAdd:   aluOp = aluAdd;
			opSub:   begin invB = 1'b1; cin = 1'b1; end   // rs + ~rt + 1
			opXor:   aluOp = aluXor;
			opAndn:  begin aluOp = aluAnd; invB = 1'b1; end
			opAddi:  begin aluSrc = 1'b1; rdIdx = instr[7:5]; end
			opSubi:  begin aluSrc = 1'b1; rdIdx = instr[7:5]; invB = 1'b1; cin = 1'b1; end
			opXori:  begin aluOp = aluXor; aluSrc = 1'b1; rdIdx = instr[7:5]; immExt = imm5Z; end
			opAndni: begin
				aluOp  = aluAnd;
				invB   = 1'b1;
				aluSrc = 1'b1;
				rdIdx  = instr[7:5];
				immExt = imm5Z;
			end
			opSll:   aluOp = aluSll;
			opSrl:   aluOp = aluSrl;
			opRol:   aluOp = aluRol;
			opRor:   aluOp = aluRor;
			opSeq:   begin cmpSet = 1'b1; cmpOp = cmpEq; invB = 1'b1; cin = 1'b1; end
			opSlt:   begin cmpSet = 1'b1; cmpOp = cmpLt; invB = 1'b1; cin = 1'b1; end
			opSle:   begin cmpSet = 1'b1; cmpOp = cmpLe; invB = 1'b1; cin = 1'b1; end
			opSco:   begin cmpSet = 1'b1; cmpOp = cmpCarry; end   // carry of rs + rt
			opBtr:   special = spBtr;
			opLbi:   begin special = spLbi; rdIdx = instr[10:8]; immExt = imm8S; end
			opSlbi:  begin special = spSlbi; rdIdx = instr[10:8]; immExt = imm8Z; end
			opJ:     begin jumpD = 1'b1; regWrite = 1'b0; end
			opJr:    begin jumpI = 1'b1; regWrite = 1'b0; immExt = imm8S; end
			default: begin illegal = 1'b1; regWrite = 1'b0; end
		endcase
	end

endmodule

// ==== src/execute.sv ====
// ********************
// execute stage
// operand select, ALU, flag analyzer,
// special results, result select, jump unit
// ********************
`timescale 1ns/1ps

module execute import execPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic [width-1:0] rsData,
	input  logic [width-1:0] rtData,
	input  logic [width-1:0] immExt,
	input  logic [width-1:0] pc,
	input  logic [10:0]      disp,
	input  aluOpT            aluOp,
	input  logic             aluSrc,
	input  logic             cin,
	input  logic             invA,
	input  logic             invB,
	input  cmpOpT            cmpOp,
	input  logic             cmpSet,
	input  specialT          special,
	input  logic             jumpD,
	input  logic             jumpI,
	output logic [width-1:0] xOut,
	output logic [width-1:0] jumpTarget,
	output logic             jumpTaken,
	output logic             jumpErr
);
	logic [width-1:0] opB;
	logic [width-1:0] aluOut;
	logic [width-1:0] rsRev;
	logic [width-1:0] extOut;
	logic [width-1:0] pcPlusTwo;
	logic             zero;
	logic             ofl;
	logic             carry;
	logic             neg;
	logic             cmpBit;

	assign opB       = aluSrc ? immExt : rtData;
	assign pcPlusTwo = pc + width'(2);

	alu #(.width(width)) alu_inst (
		.inA   (rsData),
		.inB   (opB),
		.cin   (cin),
		.invA  (invA),
		.invB  (invB),
		.oper  (aluOp),
		.out   (aluOut),
		.zero  (zero),
		.ofl   (ofl),
		.carry (carry)
	);

	assign neg = aluOut[width-1];

	// flag analyzer, signed compare of rs - rt
	always_comb begin
		case (cmpOp)
			cmpEq:    cmpBit = zero;
			cmpLt:    cmpBit = neg ^ ofl;
			cmpLe:    cmpBit = (neg ^ ofl) | zero;
			cmpCarry: cmpBit = carry;
			default:  cmpBit = 1'b0;
		endcase
	end

	always_comb begin
		for (int i = 0; i < width; i++) begin
			rsRev[i] = rsData[width-1-i];
		end
	end

	always_comb begin
		case (special)
			spBtr:   extOut = rsRev;
			spLbi:   extOut = immExt;
			spSlbi:  extOut = {rsData[width-9:0], immExt[7:0]};   // shift in a byte
			default: extOut = aluOut;
		endcase
	end

	assign xOut = cmpSet ? {{(width-1){1'b0}}, cmpBit} : extOut;

	jumpUnit #(.width(width)) jumpUnit_inst (
		.jumpD      (jumpD),
		.jumpI      (jumpI),
		.disp       (disp),
		.immExt     (immExt),
		.rs         (rsData),
		.pcPlusTwo  (pcPlusTwo),
		.jumpTarget (jumpTarget),
		.err        (jumpErr)
	);

	assign jumpTaken = jumpD | jumpI;

endmodule

// ==== src/jumpUnit.sv ====
// ********************
// jump target for J and JR
// odd target flagged as an error
// ********************
`timescale 1ns/1ps

module jumpUnit import execPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic             jumpD,
	input  logic             jumpI,
	input  logic [10:0]      disp,
	input  logic [width-1:0] immExt,
	input  logic [width-1:0] rs,
	input  logic [width-1:0] pcPlusTwo,
	output logic [width-1:0] jumpTarget,
	output logic             err
);
	logic [width-1:0] dispExt;
	logic [width-1:0] relTarget;
	logic [width-1:0] regTarget;

	assign dispExt = {{(width-11){disp[10]}}, disp};   // sign extend

	assign relTarget = pcPlusTwo + dispExt;
	assign regTarget = rs + immExt;

	assign jumpTarget = jumpI ? regTarget : relTarget;

	// targets must be halfword aligned
	assign err = (jumpD | jumpI) & jumpTarget[0];

endmodule

// ==== src/alu.sv ====
// ********************
// alu: add, logic ops, shifts and rotates
// input inversion and carry-in for subtraction
// zero, overflow and carry flags
// ********************
`timescale 1ns/1ps

module alu import execPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic [width-1:0] inA,
	input  logic [width-1:0] inB,
	input  logic             cin,
	input  logic             invA,
	input  logic             invB,
	input  aluOpT            oper,
	output logic [width-1:0] out,
	output logic             zero,
	output logic             ofl,
	output logic             carry
);
	localparam int shW = $clog2(width);

	logic [width-1:0]   opA;
	logic [width-1:0]   opB;
	logic [width:0]     sum;
	logic [2*width-1:0] rotL;
	logic [2*width-1:0] rotR;
	logic [shW-1:0]     amt;

	assign opA = invA ? ~inA : inA;
	assign opB = invB ? ~inB : inB;
	assign amt = inB[shW-1:0];   // low bits of the raw operand

	assign sum = {1'b0, opA} + {1'b0, opB} + {{width{1'b0}}, cin};

	// doubled word makes the rotates plain shifts
	assign rotL = {opA, opA} << amt;
	assign rotR = {opA, opA} >> amt;

	always_comb begin
		case (oper)
			aluAdd:  out = sum[width-1:0];
			aluAnd:  out = opA & opB;
			aluOr:   out = opA | opB;
			aluXor:  out = opA ^ opB;
			aluSll:  out = opA << amt;
			aluSrl:  out = opA >> amt;
			aluRol:  out = rotL[2*width-1:width];
			aluRor:  out = rotR[width-1:0];
			default: out = '0;
		endcase
	end

	assign zero  = (out == '0);
	assign carry = sum[width];
	// same-sign operands giving a result of the other sign
	assign ofl = (opA[width-1] == opB[width-1]) && (sum[width-1] != opA[width-1]);

endmodule

// ==== src/execPkg.sv ====
// ********************
// shared definitions for the execute core
// data width, opcode, ALU operation,
// compare and special-result encodings
// ********************
package execPkg;

	// word width, fixed by the 16-bit encoding
	localparam int dataWidth = 16;

	// instruction bits 15..11
	typedef enum logic [4:0] {
		opJ     = 5'b00100,   // pc-relative displacement jump
		opJr    = 5'b00101,   // register plus imm8
		opAddi  = 5'b01000,
		opSubi  = 5'b01001,
		opXori  = 5'b01010,
		opAndni = 5'b01011,
		opXor   = 5'b10000,
		opAndn  = 5'b10001,
		opSlbi  = 5'b10010,
		opRol   = 5'b10100,
		opSll   = 5'b10101,
		opRor   = 5'b10110,
		opSrl   = 5'b10111,
		opLbi   = 5'b11000,
		opBtr   = 5'b11001,
		opAdd   = 5'b11010,
		opSub   = 5'b11011,
		opSeq   = 5'b11100,
		opSlt   = 5'b11101,
		opSle   = 5'b11110,
		opSco   = 5'b11111
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd, aluAnd, aluOr, aluXor, aluSll, aluSrl, aluRol, aluRor
	} aluOpT;

	// flag analyzer selection
	typedef enum logic [1:0] {cmpEq, cmpLt, cmpLe, cmpCarry} cmpOpT;

	typedef enum logic [1:0] {spNone, spBtr, spLbi, spSlbi} specialT;

endpackage
